// File: hdl/harness_pkg.sv
// ----------------------------
// Address map, bus widths, boot ROM image
// and response defaults of the memory harness
// ----------------------------

package harness_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // ----------------------------
  // Address map
  // ----------------------------
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] GpioBase   = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 32'h0000_1000;
  // DRAM window length comes from the SRAM depth
  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;

  // Word index widths derived from the map
  localparam int unsigned ByteOffs     = $clog2(StrbWidth);
  localparam int unsigned RomAddrWidth = $clog2(RomLength / StrbWidth);

  // ----------------------------
  // Boot ROM image
  // ----------------------------
  localparam int unsigned RomWords    = 16;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  localparam logic [DataWidth-1:0] RomImage [RomWords] = '{
    64'h0000_0297_f140_2573, 64'h0202_8593_0182_b283,
    64'h0002_8067_0000_0013, 64'h8000_0000_0000_0000,
    64'h3007_9073_3050_5073, 64'h1050_0073_ffdf_f06f,
    64'h0010_0513_0000_0593, 64'h00b5_0633_0016_0613,
    64'hfe06_1ee3_0000_0013, 64'h0000_0000_0000_0000,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'h7b20_0073_7b30_0073, 64'h0000_006f_0000_006f,
    64'h5a5a_a5a5_3c3c_c3c3, 64'hffff_ffff_0000_0001
  };

  // Selected bus target
  typedef enum logic [1:0] {
    TgtRom,
    TgtDram,
    TgtErr
  } target_e;

  // Read data returned for writes, errors and idle cycles
  localparam logic [DataWidth-1:0] RespDataIdle = '0;

endpackage

// File: hdl/reset_sync.sv
// ----------------------------
// System reset synchronizer
// ----------------------------

`timescale 1ns/1ps

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_src_n;
  logic [1:0] sync_q;

  // Either source pulls the system into reset
  assign rst_src_n = rst_ni & ~ndmreset_i;

  // Assert async, release after two edges
  always_ff @(posedge clk_i or negedge rst_src_n) begin
    if (!rst_src_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

// File: hdl/bus_decoder.sv
// ----------------------------
// Address decoder, target strobes and
// registered response mux with error target
// ----------------------------

`timescale 1ns/1ps

module bus_decoder #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_i,
  input  logic                                      we_i,
  input  logic [harness_pkg::AddrWidth-1:0]         addr_i,
  input  logic [harness_pkg::StrbWidth-1:0]         be_i,
  input  logic [harness_pkg::DataWidth-1:0]         wdata_i,
  output logic                                      rom_req_o,
  output logic [harness_pkg::RomAddrWidth-1:0]      rom_addr_o,
  output logic                                      dram_req_o,
  output logic                                      dram_we_o,
  output logic [$clog2(NumWords)-1:0]               dram_addr_o,
  output logic [harness_pkg::StrbWidth-1:0]         dram_be_o,
  output logic [harness_pkg::DataWidth-1:0]         dram_wdata_o,
  input  logic [harness_pkg::DataWidth-1:0]         rom_rdata_i,
  input  logic [harness_pkg::DataWidth-1:0]         dram_rdata_i,
  output logic                                      resp_valid_o,
  output logic [harness_pkg::DataWidth-1:0]         rdata_o,
  output logic                                      err_o
);

  localparam int unsigned DramAw = $clog2(NumWords);
  // 64-bit bounds so a full DRAM window cannot wrap
  localparam longint unsigned RomEnd  = longint'(harness_pkg::RomBase) +
                                        longint'(harness_pkg::RomLength);
  localparam longint unsigned DramEnd = longint'(harness_pkg::DramBase) +
                                        longint'(NumWords) * harness_pkg::StrbWidth;

  harness_pkg::target_e sel;
  harness_pkg::target_e tgt_q;
  logic                 req_ok;
  logic                 valid_q;
  logic                 we_q;

  // ----------------------------
  // Request side
  // ----------------------------
  assign req_ok = req_i & rst_ni;

  always_comb begin
    if (addr_i >= harness_pkg::RomBase && longint'(addr_i) < RomEnd) begin
      sel = harness_pkg::TgtRom;
    end else if (addr_i >= harness_pkg::DramBase && longint'(addr_i) < DramEnd) begin
      sel = harness_pkg::TgtDram;
    end else begin
      // GPIO hole and everything unmapped
      sel = harness_pkg::TgtErr;
    end
  end

  // ROM writes are dropped silently
  assign rom_req_o    = req_ok & ~we_i & (sel == harness_pkg::TgtRom);
  assign rom_addr_o   = addr_i[harness_pkg::ByteOffs +: harness_pkg::RomAddrWidth];

  assign dram_req_o   = req_ok & (sel == harness_pkg::TgtDram);
  assign dram_we_o    = we_i;
  assign dram_addr_o  = addr_i[harness_pkg::ByteOffs +: DramAw];
  assign dram_be_o    = be_i;
  assign dram_wdata_o = wdata_i;

  // ----------------------------
  // Response side
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tgt_q   <= harness_pkg::TgtErr;
      we_q    <= 1'b0;
    end else begin
      valid_q <= req_ok;
      tgt_q   <= sel;
      we_q    <= we_i;
    end
  end

  assign resp_valid_o = valid_q;
  assign err_o        = valid_q & (tgt_q == harness_pkg::TgtErr);

  // Memories already hold their read data for this cycle
  always_comb begin
    rdata_o = harness_pkg::RespDataIdle;
    if (valid_q && !we_q) begin
      case (tgt_q)
        harness_pkg::TgtRom:  rdata_o = rom_rdata_i;
        harness_pkg::TgtDram: rdata_o = dram_rdata_i;
        default:              rdata_o = harness_pkg::RespDataIdle;
      endcase
    end
  end

endmodule

// File: hdl/boot_rom.sv
// ----------------------------
// Boot ROM backed by the package image
// ----------------------------

`timescale 1ns/1ps

module boot_rom (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_i,
  input  logic [harness_pkg::RomAddrWidth-1:0] addr_i,
  output logic [harness_pkg::DataWidth-1:0]    rdata_o
);

  logic                                in_image;
  logic [harness_pkg::DataWidth-1:0]   rdata_q;

  // Only the first RomWords entries hold code
  assign in_image = (addr_i < harness_pkg::RomAddrWidth'(harness_pkg::RomWords));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      if (in_image) begin
        rdata_q <= harness_pkg::RomImage[addr_i[harness_pkg::RomIdxWidth-1:0]];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hdl/data_sram.sv
// ----------------------------
// Byte-enabled single-port data SRAM
// ----------------------------

`timescale 1ns/1ps

module data_sram #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                              clk_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [$clog2(NumWords)-1:0]       addr_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  output logic [harness_pkg::DataWidth-1:0] rdata_o
);

  logic [harness_pkg::DataWidth-1:0] mem_q [NumWords];
  logic [harness_pkg::DataWidth-1:0] rdata_q;

  // ----------------------------
  // Write path
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < harness_pkg::StrbWidth; b++) begin
        // Untouched lanes keep their old byte
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------
  // Read path
  // ----------------------------
  // Output holds its last value over writes
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hdl/debug_req_gate.sv
// ----------------------------
// Debug request gate with post-reset window
// ----------------------------

`timescale 1ns/1ps

module debug_req_gate #(
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth =
    (DebugDelayCycles > 0) ? $clog2(DebugDelayCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                window_done;

  // Gives boot code time to run before a halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign window_done = (cnt_q == '0);
  assign debug_req_o = window_done & debug_req_i & debug_en_i;

endmodule

// File: hdl/harness_top.sv
// ----------------------------
// Memory harness top level
// Reset sync, decoder, boot ROM, data SRAM
// and debug request gate
// ----------------------------

`timescale 1ns/1ps

module harness_top #(
  parameter int unsigned NumWords         = 1024,
  parameter int unsigned DebugDelayCycles = 500
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              ndmreset_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  output logic                              resp_valid_o,
  output logic [harness_pkg::DataWidth-1:0] rdata_o,
  output logic                              err_o,
  input  logic                              debug_req_i,
  input  logic                              debug_en_i,
  output logic                              debug_req_o
);

  logic                                 sys_rst_n;

  logic                                 rom_req;
  logic [harness_pkg::RomAddrWidth-1:0] rom_addr;
  logic [harness_pkg::DataWidth-1:0]    rom_rdata;

  logic                                 dram_req;
  logic                                 dram_we;
  logic [$clog2(NumWords)-1:0]          dram_addr;
  logic [harness_pkg::StrbWidth-1:0]    dram_be;
  logic [harness_pkg::DataWidth-1:0]    dram_wdata;
  logic [harness_pkg::DataWidth-1:0]    dram_rdata;

  // ----------------------------
  // Reset and debug
  // ----------------------------
  reset_sync u_reset_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  // Runs on power-on reset only
  debug_req_gate #(
    .DebugDelayCycles ( DebugDelayCycles )
  ) u_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

  // ----------------------------
  // Bus and memories
  // ----------------------------
  bus_decoder #(
    .NumWords ( NumWords )
  ) u_bus_decoder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( sys_rst_n    ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .be_i         ( be_i         ),
    .wdata_i      ( wdata_i      ),
    .rom_req_o    ( rom_req      ),
    .rom_addr_o   ( rom_addr     ),
    .dram_req_o   ( dram_req     ),
    .dram_we_o    ( dram_we      ),
    .dram_addr_o  ( dram_addr    ),
    .dram_be_o    ( dram_be      ),
    .dram_wdata_o ( dram_wdata   ),
    .rom_rdata_i  ( rom_rdata    ),
    .dram_rdata_i ( dram_rdata   ),
    .resp_valid_o ( resp_valid_o ),
    .rdata_o      ( rdata_o      ),
    .err_o        ( err_o        )
  );

  boot_rom u_boot_rom (
    .clk_i   ( clk_i     ),
    .rst_ni  ( sys_rst_n ),
    .req_i   ( rom_req   ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  // Contents survive an ndmreset
  data_sram #(
    .NumWords ( NumWords )
  ) u_data_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( dram_req   ),
    .we_i    ( dram_we    ),
    .addr_i  ( dram_addr  ),
    .be_i    ( dram_be    ),
    .wdata_i ( dram_wdata ),
    .rdata_o ( dram_rdata )
  );

endmodule

// File: bench/harness_assertions.sv
// ----------------------------
// Bus decoder protocol assertions
// and their bind to bus_decoder
// ----------------------------

`timescale 1ns/1ps

module harness_assertions (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              req_ok_i,
  input logic                              rom_req_i,
  input logic                              dram_req_i,
  input logic                              resp_valid_i,
  input logic                              err_i,
  input logic [harness_pkg::DataWidth-1:0] rdata_i
);

  // Response only follows an accepted request
  resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(resp_valid_i) |-> $past(req_ok_i))
    else $error("resp_valid_o rose without an accepted request");

  err_zero_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |-> (rdata_i == '0))
    else $error("err_o raised with nonzero rdata_o");

  one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rom_req_i, dram_req_i}))
    else $error("more than one target strobe active");

endmodule

bind bus_decoder harness_assertions u_harness_assertions (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .req_ok_i     ( req_ok       ),
  .rom_req_i    ( rom_req_o    ),
  .dram_req_i   ( dram_req_o   ),
  .resp_valid_i ( resp_valid_o ),
  .err_i        ( err_o        ),
  .rdata_i      ( rdata_o      )
);

// File: bench/tb_harness_top.sv
// ----------------------------
// Testbench for harness_top
// Random bus traffic, memory model, debug gate
// and ndmreset checks
// ----------------------------

`timescale 1ns/1ps

module tb_harness_top;

  localparam int unsigned NumWords   = 1024;
  localparam int unsigned DebugDelay = 20;
  localparam longint      DramSize   = longint'(NumWords) * 8;

  logic                              clk_i = 1'b0;
  logic                              rst_ni;
  logic                              ndmreset_i;
  logic                              req_i;
  logic                              we_i;
  logic [harness_pkg::AddrWidth-1:0] addr_i;
  logic [harness_pkg::StrbWidth-1:0] be_i;
  logic [harness_pkg::DataWidth-1:0] wdata_i;
  logic                              resp_valid_o;
  logic [harness_pkg::DataWidth-1:0] rdata_o;
  logic                              err_o;
  logic                              debug_req_i;
  logic                              debug_en_i;
  logic                              debug_req_o;

  integer      seed = 32'h338f_39f6;
  int          errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          edges = 0;

  // Expected response for the request now in flight
  logic        exp_valid = 1'b0;
  logic        exp_err = 1'b0;
  logic [63:0] exp_data = '0;
  logic [63:0] sram_model [int unsigned];

  always #50 clk_i = ~clk_i;

  harness_top #(
    .NumWords         ( NumWords   ),
    .DebugDelayCycles ( DebugDelay )
  ) u_harness_top (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ndmreset_i   ( ndmreset_i   ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .be_i         ( be_i         ),
    .wdata_i      ( wdata_i      ),
    .resp_valid_o ( resp_valid_o ),
    .rdata_o      ( rdata_o      ),
    .err_o        ( err_o        ),
    .debug_req_i  ( debug_req_i  ),
    .debug_en_i   ( debug_en_i   ),
    .debug_req_o  ( debug_req_o  )
  );

  // ----------------------------
  // Model helpers
  // ----------------------------
  function automatic logic in_rom(input logic [31:0] addr);
    return (addr >= harness_pkg::RomBase) &&
           ((addr - harness_pkg::RomBase) < harness_pkg::RomLength);
  endfunction

  function automatic logic in_dram(input logic [31:0] addr);
    return (addr >= harness_pkg::DramBase) &&
           (longint'(addr - harness_pkg::DramBase) < DramSize);
  endfunction

  function automatic logic [31:0] dram_addr(input int unsigned idx);
    return harness_pkg::DramBase + 32'(idx * 8);
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic mismatch(input string name, input logic [63:0] got,
                          input logic [63:0] exp);
    errors++;
    $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic check_response();
    assert (resp_valid_o === exp_valid)
      else mismatch("resp_valid_o", 64'(resp_valid_o), 64'(exp_valid));
    assert (err_o === exp_err)
      else mismatch("err_o", 64'(err_o), 64'(exp_err));
    assert (rdata_o === exp_data)
      else mismatch("rdata_o", rdata_o, exp_data);
  endtask

  // Checks the last response, then drives one request and predicts its reply
  task automatic bus_cycle(input logic req, input logic we, input logic [31:0] addr,
                           input logic [7:0] be, input logic [63:0] wdata);
    int unsigned idx;
    logic [63:0] word;
    @(posedge clk_i);
    #1;
    check_response();
    req_i     = req;
    we_i      = we;
    addr_i    = addr;
    be_i      = be;
    wdata_i   = wdata;
    exp_valid = req;
    exp_err   = 1'b0;
    exp_data  = '0;
    if (req) begin
      if (in_rom(addr)) begin
        idx = (addr - harness_pkg::RomBase) >> 3;
        if (!we && idx < harness_pkg::RomWords) begin
          exp_data = harness_pkg::RomImage[idx];
        end
      end else if (in_dram(addr)) begin
        idx  = (addr - harness_pkg::DramBase) >> 3;
        word = sram_model.exists(idx) ? sram_model[idx] : '0;
        if (we) begin
          for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
              word[b*8 +: 8] = wdata[b*8 +: 8];
            end
          end
          sram_model[idx] = word;
        end else begin
          exp_data = word;
        end
      end else begin
        exp_err = 1'b1;
      end
    end
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  // ----------------------------
  // Tests
  // ----------------------------
  task automatic run_reset();
    for (int i = 0; i < 13; i++) begin
      @(posedge clk_i);
      #1;
      if (i == 9) begin
        rst_ni = 1'b1;
      end
      if (i >= 10) begin
        edges++;
      end
      check_response();
      assert (debug_req_o === 1'b0)
        else mismatch("debug_req_o", 64'(debug_req_o), 64'd0);
    end
  endtask

  task automatic run_debug_gate();
    // Inputs stay high from reset until the window closes
    while (edges < 60) begin
      @(posedge clk_i);
      #1;
      edges++;
      check_response();
      if (edges < DebugDelay) begin
        assert (debug_req_o === 1'b0)
          else mismatch("debug_req_o", 64'(debug_req_o), 64'd0);
      end else if (edges > DebugDelay) begin
        assert (debug_req_o === (debug_req_i & debug_en_i))
          else mismatch("debug_req_o", 64'(debug_req_o), 64'(debug_req_i & debug_en_i));
      end
      if (edges >= DebugDelay) begin
        debug_req_i = 1'($random(seed));
        debug_en_i  = 1'($random(seed));
      end
    end
    debug_req_i = 1'b0;
    debug_en_i  = 1'b0;
  endtask

  task automatic run_sram_traffic();
    int unsigned r;
    int unsigned idx;
    logic        we;
    logic [7:0]  be;
    // Working set with known contents
    for (int i = 0; i < 64; i++) begin
      bus_cycle(1'b1, 1'b1, dram_addr(i), 8'hff, rand64());
    end
    for (int i = 0; i < 300; i++) begin
      r   = $random(seed);
      idx = (r % 8 == 0) ? (r >> 3) % NumWords : (r >> 3) % 64;
      we  = 1'($random(seed));
      be  = 8'($random(seed));
      if (!sram_model.exists(idx)) begin
        we = 1'b1;
        be = 8'hff;
      end
      bus_cycle(1'b1, we, dram_addr(idx), be, rand64());
    end
    idle_cycle();
  endtask

  task automatic run_rom();
    int unsigned r;
    for (int i = 0; i < harness_pkg::RomWords + 4; i++) begin
      bus_cycle(1'b1, 1'b0, harness_pkg::RomBase + 32'(i * 8), '0, '0);
    end
    for (int i = 0; i < 30; i++) begin
      r = $random(seed);
      bus_cycle(1'b1, 1'b0, harness_pkg::RomBase + 32'((r % 512) * 8), '0, '0);
    end
    // Writes are dropped, image reads back unchanged
    for (int i = 0; i < 10; i++) begin
      r = $random(seed);
      bus_cycle(1'b1, 1'b1, harness_pkg::RomBase + 32'((r % 16) * 8), 8'hff, rand64());
    end
    for (int i = 0; i < harness_pkg::RomWords; i++) begin
      bus_cycle(1'b1, 1'b0, harness_pkg::RomBase + 32'(i * 8), '0, '0);
    end
    idle_cycle();
  endtask

  task automatic run_err_target();
    logic [31:0] addr;
    for (int i = 0; i < 16; i++) begin
      addr = harness_pkg::GpioBase + ((32'($random(seed)) % harness_pkg::GpioLength) & ~32'h7);
      bus_cycle(1'b1, 1'($random(seed)), addr, 8'hff, rand64());
    end
    // Window edges
    bus_cycle(1'b1, 1'b0, harness_pkg::RomBase - 32'h8, '0, '0);
    bus_cycle(1'b1, 1'b0, harness_pkg::RomBase + harness_pkg::RomLength, '0, '0);
    bus_cycle(1'b1, 1'b0, 32'(longint'(harness_pkg::DramBase) + DramSize), '0, '0);
    for (int i = 0; i < 32; i++) begin
      addr = $random(seed);
      if (in_rom(addr) || in_dram(addr)) begin
        addr[31:28] = 4'h6;
      end
      bus_cycle(1'b1, 1'($random(seed)), addr, 8'($random(seed)), rand64());
    end
    idle_cycle();
  endtask

  task automatic run_ndmreset();
    int unsigned idx;
    int          waited;
    logic        seen;
    logic [63:0] keep;
    idx = 7;
    bus_cycle(1'b1, 1'b1, dram_addr(idx), 8'hff, 64'h1357_9bdf_2468_ace0);
    keep = sram_model[idx];
    idle_cycle();
    @(posedge clk_i);
    #1;
    check_response();
    ndmreset_i = 1'b1;
    req_i      = 1'b1;
    we_i       = 1'b0;
    addr_i     = dram_addr(idx);
    be_i       = '0;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk_i);
      #1;
      assert (resp_valid_o === 1'b0 && err_o === 1'b0) else begin
        errors++;
        $display("ndmreset: response seen while the system reset is held");
      end
    end
    ndmreset_i = 1'b0;
    waited     = 0;
    seen       = 1'b0;
    while (!seen && waited < 20) begin
      @(posedge clk_i);
      #1;
      waited++;
      seen = resp_valid_o;
    end
    if (!seen) begin
      errors++;
      $display("ndmreset: no response within 20 cycles after release");
    end else begin
      // Sync releases on the 2nd edge, first accept on the 3rd
      assert (waited == 3) else begin
        errors++;
        $display("ndmreset: first response %0d cycles after release, expected 3", waited);
      end
      assert (rdata_o === keep) else mismatch("rdata_o", rdata_o, keep);
      assert (err_o === 1'b0) else mismatch("err_o", 64'(err_o), 64'd0);
    end
    exp_valid = 1'b1;
    exp_err   = 1'b0;
    exp_data  = keep;
    for (int i = 0; i < 8; i++) begin
      bus_cycle(1'b1, 1'b0, dram_addr(i), '0, '0);
    end
    idle_cycle();
  endtask

  // ----------------------------
  // Main sequence
  // ----------------------------
  initial begin
    int mark;
    rst_ni      = 1'b0;
    ndmreset_i  = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    be_i        = '0;
    wdata_i     = '0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;

    mark = errors;
    run_reset();
    end_test("reset", mark);
    mark = errors;
    run_debug_gate();
    end_test("debug_gate", mark);
    mark = errors;
    run_sram_traffic();
    end_test("sram_traffic", mark);
    mark = errors;
    run_rom();
    end_test("rom", mark);
    mark = errors;
    run_err_target();
    end_test("err_target", mark);
    mark = errors;
    run_ndmreset();
    end_test("ndmreset", mark);

    $display("tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/harness_pkg.sv
hdl/reset_sync.sv
hdl/bus_decoder.sv
hdl/boot_rom.sv
hdl/data_sram.sv
hdl/debug_req_gate.sv
hdl/harness_top.sv
bench/harness_assertions.sv
bench/tb_harness_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log \
  && verilator --binary --timing --assert -Wno-fatal \
       -f list.f --top-module tb_harness_top \
  && ./obj_dir/Vtb_harness_top | tee sim.log \
  && grep -q "ALL TESTS PASSED" sim.log \
  && echo "simulation run: pass" \
  || { echo "simulation run: fail"; exit 1; }
